//--- verilog/dcache_pkg.sv
package dcache_pkg;

    // processor side
    localparam int FE_ADDR_W = 16;
    localparam int FE_DATA_W = 32;
    localparam int FE_NBYTES = FE_DATA_W / 8;
    localparam int FE_BYTE_W = $clog2(FE_NBYTES);

    // bit that selects control space
    localparam int CTRL_BIT = FE_ADDR_W - 1;

    // cache geometry
    localparam int WORD_OFF_W = 2;
    localparam int LINE_WORDS = 2 ** WORD_OFF_W;
    localparam int INDEX_W    = 4;
    localparam int NLINES     = 2 ** INDEX_W;
    localparam int TAG_W      = FE_ADDR_W - 1 - INDEX_W - WORD_OFF_W - FE_BYTE_W;

    // line address is tag plus index, memory port uses word addresses
    localparam int LINE_ADDR_W = TAG_W + INDEX_W;
    localparam int MEM_ADDR_W  = FE_ADDR_W - FE_BYTE_W;

    localparam int CNT_W = 16;

    typedef logic [CNT_W-1:0] cnt_t;

    typedef struct packed {
        logic [FE_ADDR_W-1:0] addr;
        logic [FE_DATA_W-1:0] wdata;
        logic [FE_NBYTES-1:0] wstrb;
        logic                 we;
    } fe_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [MEM_ADDR_W-1:0] addr;
        logic [FE_DATA_W-1:0]  wdata;
        logic [FE_NBYTES-1:0]  wstrb;
    } mem_req_t;

    // read data, or just an acknowledge for writes
    typedef struct packed {
        logic                 valid;
        logic [FE_DATA_W-1:0] rdata;
    } mem_resp_t;

    typedef struct packed {
        logic read_hit;
        logic read_miss;
        logic write_hit;
        logic write_miss;
    } hit_ev_t;

endpackage

//--- verilog/cache_frontend.sv
module cache_frontend
    import dcache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,

    input  logic                 valid_i,
    input  logic [FE_ADDR_W-1:0] addr_i,
    input  logic [FE_DATA_W-1:0] wdata_i,
    input  logic [FE_NBYTES-1:0] wstrb_i,
    output logic [FE_DATA_W-1:0] rdata_o,
    output logic                 ready_o,

    output fe_req_t              req_o,
    output logic                 cache_req_o,
    output logic                 ctrl_req_o,
    input  logic                 cache_done_i,
    input  logic                 ctrl_done_i,
    input  logic [FE_DATA_W-1:0] cache_rdata_i,
    input  logic [FE_DATA_W-1:0] ctrl_rdata_i
);

    logic    busy_q;
    fe_req_t req_q;

    // request payload, held until the access completes
    always_ff @(posedge clk) begin
        if (!busy_q && valid_i) begin
            req_q.addr  <= addr_i;
            req_q.wdata <= wdata_i;
            req_q.wstrb <= wstrb_i;
            req_q.we    <= |wstrb_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q      <= 1'b0;
            cache_req_o <= 1'b0;
            ctrl_req_o  <= 1'b0;
        end else begin
            cache_req_o <= 1'b0;
            ctrl_req_o  <= 1'b0;
            if (!busy_q && valid_i) begin
                busy_q      <= 1'b1;
                cache_req_o <= !addr_i[CTRL_BIT];
                ctrl_req_o  <= addr_i[CTRL_BIT];
            end else if (ready_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign req_o   = req_q;
    assign ready_o = cache_done_i | ctrl_done_i;
    assign rdata_o = ctrl_done_i ? ctrl_rdata_i : cache_rdata_i;

    // only one target can be active per request
    assert property (@(posedge clk) disable iff (!rst_n_i)
        !(cache_done_i && ctrl_done_i));

endmodule

//--- verilog/cache_memory.sv
module cache_memory
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  fe_req_t                req_i,
    input  logic                   cache_req_i,
    output logic                   cache_done_o,
    output logic [FE_DATA_W-1:0]   cache_rdata_o,

    output logic                   refill_req_o,
    output logic [LINE_ADDR_W-1:0] refill_addr_o,
    input  logic                   refill_word_i,
    input  logic [WORD_OFF_W-1:0]  refill_off_i,
    input  logic [FE_DATA_W-1:0]   refill_data_i,
    input  logic                   refill_done_i,
    output logic                   wt_req_o,
    input  logic                   wt_done_i,

    input  logic                   invalidate_i,
    output hit_ev_t                hit_ev_o
);

    typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_REFILL, S_WRITE} state_t;

    state_t state_q;

    logic [TAG_W-1:0]     tag_mem  [NLINES];
    logic [FE_DATA_W-1:0] data_mem [NLINES][LINE_WORDS];
    logic [NLINES-1:0]    valid_q;

    logic [TAG_W-1:0]      tag_rd_q;
    logic [FE_DATA_W-1:0]  data_rd_q;
    logic [FE_DATA_W-1:0]  fill_word_q;
    logic [INDEX_W-1:0]    idx;
    logic [WORD_OFF_W-1:0] off;
    logic [TAG_W-1:0]      tag;
    logic                  hit;
    logic                  lookup;
    logic                  fill_match;

    assign off = req_i.addr[FE_BYTE_W +: WORD_OFF_W];
    assign idx = req_i.addr[FE_BYTE_W+WORD_OFF_W +: INDEX_W];
    assign tag = req_i.addr[FE_BYTE_W+WORD_OFF_W+INDEX_W +: TAG_W];

    assign lookup     = (state_q == S_LOOKUP);
    assign hit        = valid_q[idx] && (tag_rd_q == tag);
    assign fill_match = refill_word_i && (refill_off_i == off);

    // arrays and read registers
    always_ff @(posedge clk) begin
        if (cache_req_i) begin
            tag_rd_q  <= tag_mem[idx];
            data_rd_q <= data_mem[idx][off];
        end
        if (lookup && req_i.we && hit) begin
            for (int b = 0; b < FE_NBYTES; b++) begin
                if (req_i.wstrb[b])
                    data_mem[idx][off][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
        end
        if (state_q == S_REFILL && refill_word_i) begin
            data_mem[idx][refill_off_i] <= refill_data_i;
            if (fill_match)
                fill_word_q <= refill_data_i;
        end
        if (state_q == S_REFILL && refill_done_i)
            tag_mem[idx] <= tag;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            valid_q <= '0;
        end else begin
            if (invalidate_i)
                valid_q <= '0;
            case (state_q)
                S_IDLE:   if (cache_req_i) state_q <= S_LOOKUP;
                S_LOOKUP: begin
                    if (req_i.we)
                        state_q <= S_WRITE;
                    else if (!hit)
                        state_q <= S_REFILL;
                    else
                        state_q <= S_IDLE;
                end
                S_REFILL: begin
                    if (refill_done_i) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= S_IDLE;
                    end
                end
                default:  if (wt_done_i) state_q <= S_IDLE;
            endcase
        end
    end

    assign refill_addr_o = {tag, idx};
    assign refill_req_o  = lookup && !req_i.we && !hit;
    assign wt_req_o      = lookup && req_i.we;

    assign hit_ev_o.read_hit   = lookup && !req_i.we && hit;
    assign hit_ev_o.read_miss  = lookup && !req_i.we && !hit;
    assign hit_ev_o.write_hit  = lookup && req_i.we && hit;
    assign hit_ev_o.write_miss = lookup && req_i.we && !hit;

    always_comb begin
        cache_done_o  = 1'b0;
        cache_rdata_o = data_rd_q;
        case (state_q)
            S_LOOKUP: cache_done_o = !req_i.we && hit;
            S_REFILL: begin
                cache_done_o  = refill_done_i;
                // requested word may be the last one of the stream
                cache_rdata_o = fill_match ? refill_data_i : fill_word_q;
            end
            S_WRITE:  cache_done_o = wt_done_i;
            default:  cache_done_o = 1'b0;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        refill_word_i |-> state_q == S_REFILL);

    // write-through completes only while one is pending
    assert property (@(posedge clk) disable iff (!rst_n_i)
        wt_done_i |-> state_q == S_WRITE);

endmodule

//--- verilog/cache_backend.sv
module cache_backend
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  fe_req_t                req_i,
    input  logic                   refill_req_i,
    input  logic [LINE_ADDR_W-1:0] refill_addr_i,
    output logic                   refill_word_o,
    output logic [WORD_OFF_W-1:0]  refill_off_o,
    output logic [FE_DATA_W-1:0]   refill_data_o,
    output logic                   refill_done_o,
    input  logic                   wt_req_i,
    output logic                   wt_done_o,

    output mem_req_t               mem_req_o,
    input  mem_resp_t              mem_resp_i
);

    typedef enum logic [1:0] {S_IDLE, S_READ, S_WRITE} state_t;

    state_t                 state_q;
    logic [WORD_OFF_W-1:0]  cnt_q;
    logic [LINE_ADDR_W-1:0] line_q;
    mem_req_t               mem_req_q;
    logic                   last_word;

    assign last_word = (cnt_q == WORD_OFF_W'(LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q         <= S_IDLE;
            cnt_q           <= '0;
            mem_req_q.valid <= 1'b0;
        end else begin
            mem_req_q.valid <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (refill_req_i) begin
                        line_q          <= refill_addr_i;
                        cnt_q           <= '0;
                        mem_req_q.valid <= 1'b1;
                        mem_req_q.we    <= 1'b0;
                        mem_req_q.addr  <= {1'b0, refill_addr_i, {WORD_OFF_W{1'b0}}};
                        mem_req_q.wstrb <= '0;
                        state_q         <= S_READ;
                    end else if (wt_req_i) begin
                        mem_req_q.valid <= 1'b1;
                        mem_req_q.we    <= 1'b1;
                        mem_req_q.addr  <= req_i.addr[FE_ADDR_W-1:FE_BYTE_W];
                        mem_req_q.wdata <= req_i.wdata;
                        mem_req_q.wstrb <= req_i.wstrb;
                        state_q         <= S_WRITE;
                    end
                end
                S_READ: begin
                    if (mem_resp_i.valid) begin
                        if (last_word) begin
                            state_q <= S_IDLE;
                        end else begin
                            // next word of the line
                            cnt_q           <= cnt_q + 1'b1;
                            mem_req_q.valid <= 1'b1;
                            mem_req_q.addr  <= {1'b0, line_q, cnt_q + 1'b1};
                        end
                    end
                end
                default: if (mem_resp_i.valid) state_q <= S_IDLE;
            endcase
        end
    end

    assign mem_req_o     = mem_req_q;
    assign refill_word_o = (state_q == S_READ) && mem_resp_i.valid;
    assign refill_off_o  = cnt_q;
    assign refill_data_o = mem_resp_i.rdata;
    assign refill_done_o = refill_word_o && last_word;
    assign wt_done_o     = (state_q == S_WRITE) && mem_resp_i.valid;

    // memory only answers what was asked
    assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_resp_i.valid |-> state_q != S_IDLE);

endmodule

//--- verilog/cache_control.sv
module cache_control
    import dcache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,

    input  fe_req_t              req_i,
    input  logic                 ctrl_req_i,
    output logic                 ctrl_done_o,
    output logic [FE_DATA_W-1:0] ctrl_rdata_o,

    input  hit_ev_t              hit_ev_i,
    output logic                 invalidate_o
);

    cnt_t                  cnt_q [4];
    logic [3:0]            ev_vec;
    logic [WORD_OFF_W-1:0] sel;

    // order matches the control word offsets
    assign ev_vec = {hit_ev_i.write_miss, hit_ev_i.write_hit,
                     hit_ev_i.read_miss, hit_ev_i.read_hit};
    assign sel    = req_i.addr[FE_BYTE_W +: WORD_OFF_W];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 4; i++)
                cnt_q[i] <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                // saturate instead of wrapping
                if (ev_vec[i] && cnt_q[i] != '1)
                    cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctrl_done_o  <= 1'b0;
            invalidate_o <= 1'b0;
        end else begin
            ctrl_done_o  <= ctrl_req_i;
            invalidate_o <= ctrl_req_i && req_i.we;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_req_i)
            ctrl_rdata_o <= {{(FE_DATA_W-CNT_W){1'b0}}, cnt_q[sel]};
    end

endmodule

//--- verilog/dcache_top.sv
module dcache_top
    import dcache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,

    input  logic                 valid_i,
    input  logic [FE_ADDR_W-1:0] addr_i,
    input  logic [FE_DATA_W-1:0] wdata_i,
    input  logic [FE_NBYTES-1:0] wstrb_i,
    output logic [FE_DATA_W-1:0] rdata_o,
    output logic                 ready_o,

    output mem_req_t             mem_req_o,
    input  mem_resp_t            mem_resp_i
);

    fe_req_t                req;
    logic                   cache_req, ctrl_req;
    logic                   cache_done, ctrl_done;
    logic [FE_DATA_W-1:0]   cache_rdata, ctrl_rdata;

    // refill and write-through handshake
    logic                   refill_req, refill_word, refill_done;
    logic [LINE_ADDR_W-1:0] refill_addr;
    logic [WORD_OFF_W-1:0]  refill_off;
    logic [FE_DATA_W-1:0]   refill_data;
    logic                   wt_req, wt_done;

    logic                   invalidate;
    hit_ev_t                hit_ev;

    cache_frontend u_cache_frontend (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .valid_i       (valid_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .wstrb_i       (wstrb_i),
        .rdata_o       (rdata_o),
        .ready_o       (ready_o),
        .req_o         (req),
        .cache_req_o   (cache_req),
        .ctrl_req_o    (ctrl_req),
        .cache_done_i  (cache_done),
        .ctrl_done_i   (ctrl_done),
        .cache_rdata_i (cache_rdata),
        .ctrl_rdata_i  (ctrl_rdata)
    );

    cache_memory u_cache_memory (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .req_i         (req),
        .cache_req_i   (cache_req),
        .cache_done_o  (cache_done),
        .cache_rdata_o (cache_rdata),
        .refill_req_o  (refill_req),
        .refill_addr_o (refill_addr),
        .refill_word_i (refill_word),
        .refill_off_i  (refill_off),
        .refill_data_i (refill_data),
        .refill_done_i (refill_done),
        .wt_req_o      (wt_req),
        .wt_done_i     (wt_done),
        .invalidate_i  (invalidate),
        .hit_ev_o      (hit_ev)
    );

    cache_backend u_cache_backend (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .req_i         (req),
        .refill_req_i  (refill_req),
        .refill_addr_i (refill_addr),
        .refill_word_o (refill_word),
        .refill_off_o  (refill_off),
        .refill_data_o (refill_data),
        .refill_done_o (refill_done),
        .wt_req_i      (wt_req),
        .wt_done_o     (wt_done),
        .mem_req_o     (mem_req_o),
        .mem_resp_i    (mem_resp_i)
    );

    cache_control u_cache_control (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .req_i         (req),
        .ctrl_req_i    (ctrl_req),
        .ctrl_done_o   (ctrl_done),
        .ctrl_rdata_o  (ctrl_rdata),
        .hit_ev_i      (hit_ev),
        .invalidate_o  (invalidate)
    );

endmodule

//--- test/tb_dcache.sv
module tb_dcache
    import dcache_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 100;
    localparam int MEM_WORDS      = 2 ** MEM_ADDR_W;

    logic                 clk = 1'b0;
    logic                 rst_n_i;
    logic                 valid_i;
    logic [FE_ADDR_W-1:0] addr_i;
    logic [FE_DATA_W-1:0] wdata_i;
    logic [FE_NBYTES-1:0] wstrb_i;
    logic [FE_DATA_W-1:0] rdata_o;
    logic                 ready_o;
    mem_req_t             mem_req_o;
    mem_resp_t            mem_resp = '0;

    logic [31:0]          stim_lfsr = 32'h45e7;
    logic [31:0]          resp_lfsr = 32'h45e7;

    // memory seen by the DUT, and the expected contents
    logic [FE_DATA_W-1:0] mem_array [MEM_WORDS];
    logic [FE_DATA_W-1:0] ref_mem   [MEM_WORDS];
    mem_req_t             mem_log [$];
    mem_req_t             held_req;
    int                   resp_wait;

    // cache model
    logic [TAG_W-1:0]     model_tag [NLINES];
    logic [NLINES-1:0]    model_valid;
    cnt_t                 model_cnt [4];

    int                   checks;
    int                   errors;
    logic                 stalled;

    always #4 clk = ~clk;

    dcache_top u_dcache_top (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .wstrb_i    (wstrb_i),
        .rdata_o    (rdata_o),
        .ready_o    (ready_o),
        .mem_req_o  (mem_req_o),
        .mem_resp_i (mem_resp)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] st);
        return st[0] ? ((st >> 1) ^ 32'h80200003) : (st >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n, inout logic [31:0] st);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v  = {v[30:0], st[0]};
            st = lfsr_step(st);
        end
        return v;
    endfunction

    function automatic logic [FE_DATA_W-1:0] fill_pattern(input logic [MEM_ADDR_W-1:0] a);
        return {a, 2'b01, ~a, 2'b10};
    endfunction

    // few tags per index so that hits are common
    function automatic logic [FE_ADDR_W-1:0] rand_cache_addr();
        logic [TAG_W-1:0]      t;
        logic [INDEX_W-1:0]    i;
        logic [WORD_OFF_W-1:0] w;
        t = TAG_W'(rand_bits(2, stim_lfsr) * 37);
        i = INDEX_W'(rand_bits(INDEX_W, stim_lfsr));
        w = WORD_OFF_W'(rand_bits(WORD_OFF_W, stim_lfsr));
        return {1'b0, t, i, w, {FE_BYTE_W{1'b0}}};
    endfunction

    function automatic logic [FE_ADDR_W-1:0] ctrl_addr(input logic [WORD_OFF_W-1:0] off);
        return {1'b1, {(FE_ADDR_W-1-WORD_OFF_W-FE_BYTE_W){1'b0}}, off, {FE_BYTE_W{1'b0}}};
    endfunction

    // counts the access and allocates on a read miss only
    function automatic logic model_lookup(input logic [FE_ADDR_W-1:0] a, input logic is_write);
        logic [INDEX_W-1:0] i;
        logic [TAG_W-1:0]   t;
        logic               hit;
        int                 k;
        i   = a[FE_BYTE_W+WORD_OFF_W +: INDEX_W];
        t   = a[FE_BYTE_W+WORD_OFF_W+INDEX_W +: TAG_W];
        hit = model_valid[i] && (model_tag[i] == t);
        k   = is_write ? (hit ? 2 : 3) : (hit ? 0 : 1);
        if (model_cnt[k] != '1)
            model_cnt[k] = model_cnt[k] + 1'b1;
        if (!is_write && !hit) begin
            model_valid[i] = 1'b1;
            model_tag[i]   = t;
        end
        return hit;
    endfunction

    // memory port responder, one request at a time
    always @(posedge clk) begin
        mem_resp.valid <= 1'b0;
        if (!rst_n_i) begin
            resp_wait = 0;
            for (int w = 0; w < MEM_WORDS; w++)
                mem_array[w] = fill_pattern(MEM_ADDR_W'(w));
        end else if (resp_wait > 0) begin
            resp_wait = resp_wait - 1;
            if (resp_wait == 0) begin
                if (held_req.we) begin
                    for (int b = 0; b < FE_NBYTES; b++) begin
                        if (held_req.wstrb[b])
                            mem_array[held_req.addr][8*b +: 8] = held_req.wdata[8*b +: 8];
                    end
                end else begin
                    mem_resp.rdata <= mem_array[held_req.addr];
                end
                mem_resp.valid <= 1'b1;
            end
        end else if (mem_req_o.valid) begin
            held_req = mem_req_o;
            mem_log.push_back(mem_req_o);
            resp_wait = 1 + int'(rand_bits(2, resp_lfsr));
        end
    end

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_word(input string name, input logic [FE_DATA_W-1:0] got,
                              input logic [FE_DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    // read requests carry stale write data
    task automatic match_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
        logic bad;
        checks++;
        bad = got.valid !== exp.valid || got.we !== exp.we || got.addr !== exp.addr
              || got.wstrb !== exp.wstrb || (exp.we && got.wdata !== exp.wdata);
        if (bad) begin
            errors++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input cnt_t got, input cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    // one processor access, lat counts cycles from the first valid cycle to ready
    task automatic access(input logic [FE_ADDR_W-1:0] a, input logic [FE_DATA_W-1:0] wd,
                          input logic [FE_NBYTES-1:0] ws, output logic [FE_DATA_W-1:0] rd,
                          output int lat);
        int n;
        rd  = '0;
        lat = -1;
        n   = 0;
        if (stalled)
            return;
        mem_log.delete();
        @(posedge clk);
        valid_i <= 1'b1;
        addr_i  <= a;
        wdata_i <= wd;
        wstrb_i <= ws;
        while (lat < 0 && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            if (ready_o) begin
                lat = n;
                rd  = rdata_o;
            end
            n++;
        end
        valid_i <= 1'b0;
        wstrb_i <= '0;
        if (lat < 0) begin
            stalled = 1'b1;
            note_failure($sformatf("no ready_o within %0d cycles for address %h",
                                   TIMEOUT_CYCLES, a));
        end
    endtask

    task automatic cache_read(input logic [FE_ADDR_W-1:0] a);
        logic                 hit;
        logic [FE_DATA_W-1:0] rd;
        int                   lat;
        mem_req_t             exp;
        hit = model_lookup(a, 1'b0);
        access(a, '0, '0, rd, lat);
        if (stalled)
            return;
        check_word("rdata_o", rd, ref_mem[a[FE_ADDR_W-1:FE_BYTE_W]]);
        if (hit) begin
            checks++;
            if (lat != 2 || mem_log.size() != 0)
                note_failure($sformatf("read hit at %h took %0d cycles with %0d memory requests",
                                       a, lat, mem_log.size()));
        end else if (mem_log.size() != LINE_WORDS) begin
            note_failure($sformatf("read miss at %h made %0d memory requests instead of %0d",
                                   a, mem_log.size(), LINE_WORDS));
        end else begin
            // whole line, words in order
            for (int w = 0; w < LINE_WORDS; w++) begin
                exp       = '0;
                exp.valid = 1'b1;
                exp.addr  = {a[FE_ADDR_W-1:FE_BYTE_W+WORD_OFF_W], WORD_OFF_W'(w)};
                match_mem_req("mem_req_o", mem_log[w], exp);
            end
        end
    endtask

    task automatic cache_write(input logic [FE_ADDR_W-1:0] a);
        logic [FE_DATA_W-1:0] wd;
        logic [FE_NBYTES-1:0] ws;
        logic [FE_DATA_W-1:0] rd;
        int                   lat;
        mem_req_t             exp;
        wd = rand_bits(FE_DATA_W, stim_lfsr);
        ws = FE_NBYTES'(rand_bits(FE_NBYTES, stim_lfsr));
        // an empty strobe would turn the access into a read
        if (ws == '0)
            ws = '1;
        void'(model_lookup(a, 1'b1));
        access(a, wd, ws, rd, lat);
        if (stalled)
            return;
        for (int b = 0; b < FE_NBYTES; b++) begin
            if (ws[b])
                ref_mem[a[FE_ADDR_W-1:FE_BYTE_W]][8*b +: 8] = wd[8*b +: 8];
        end
        if (mem_log.size() != 1) begin
            note_failure($sformatf("write at %h made %0d memory requests instead of 1",
                                   a, mem_log.size()));
        end else begin
            exp       = '0;
            exp.valid = 1'b1;
            exp.we    = 1'b1;
            exp.addr  = a[FE_ADDR_W-1:FE_BYTE_W];
            exp.wdata = wd;
            exp.wstrb = ws;
            match_mem_req("mem_req_o", mem_log[0], exp);
        end
    endtask

    task automatic read_counter(input logic [WORD_OFF_W-1:0] off);
        logic [FE_DATA_W-1:0] rd;
        int                   lat;
        access(ctrl_addr(off), '0, '0, rd, lat);
        if (stalled)
            return;
        compare_count($sformatf("rdata_o counter %0d", off), rd[CNT_W-1:0], model_cnt[off]);
        if (lat != 2)
            note_failure($sformatf("control read took %0d cycles instead of 2", lat));
    endtask

    task automatic invalidate_all();
        logic [FE_DATA_W-1:0] rd;
        int                   lat;
        model_valid = '0;
        access(ctrl_addr('0), 32'h1, '1, rd, lat);
        if (stalled)
            return;
        checks++;
        if (lat != 2 || mem_log.size() != 0)
            note_failure($sformatf("control write took %0d cycles with %0d memory requests",
                                   lat, mem_log.size()));
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        if (errors == errs_at_start)
            $display("%s: ok", name);
        else
            $display("%s: failed with %0d errors", name, errors - errs_at_start);
    endtask

    initial begin
        int                   e0;
        logic [FE_ADDR_W-1:0] a;
        checks      = 0;
        errors      = 0;
        stalled     = 1'b0;
        model_valid = '0;
        for (int k = 0; k < 4; k++)
            model_cnt[k] = '0;
        for (int w = 0; w < MEM_WORDS; w++)
            ref_mem[w] = fill_pattern(MEM_ADDR_W'(w));
        rst_n_i = 1'b0;
        valid_i = 1'b0;
        addr_i  = '0;
        wdata_i = '0;
        wstrb_i = '0;
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;

        e0 = errors;
        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            checks++;
            if (ready_o !== 1'b0 || mem_req_o.valid !== 1'b0)
                note_failure($sformatf("outputs active while idle: ready_o %b, mem_req_o.valid %b",
                                       ready_o, mem_req_o.valid));
        end
        report_test("test 1 reset state", e0);

        e0 = errors;
        a  = rand_cache_addr();
        cache_read(a);
        cache_read(a);
        report_test("test 2 read miss then hit", e0);

        e0 = errors;
        for (int t = 0; t < 12; t++) begin
            a = rand_cache_addr();
            // cache the line first on about half the rounds
            if (rand_bits(1, stim_lfsr) != 0)
                cache_read(a);
            cache_write(a);
            cache_read(a);
        end
        report_test("test 3 write-through with strobes", e0);

        e0 = errors;
        for (int t = 0; t < 200; t++) begin
            a = rand_cache_addr();
            if (rand_bits(1, stim_lfsr) != 0)
                cache_write(a);
            else
                cache_read(a);
        end
        for (int k = 0; k < 4; k++)
            read_counter(WORD_OFF_W'(k));
        report_test("test 4 counters", e0);

        e0 = errors;
        a  = rand_cache_addr();
        cache_read(a);
        invalidate_all();
        cache_read(a);
        read_counter(WORD_OFF_W'(1));
        report_test("test 5 invalidate", e0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- compile.f
verilog/dcache_pkg.sv
verilog/cache_frontend.sv
verilog/cache_memory.sv
verilog/cache_backend.sv
verilog/cache_control.sv
verilog/dcache_top.sv
test/tb_dcache.sv

//--- run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dcache -f compile.f -o tb_dcache

./obj_dir/tb_dcache | tee sim.log

grep -q "TEST RESULT: PASS" sim.log
